// File: dv/int_backend_tests.txt
# U <uop hex> <repeat>      micro-op word, sent repeat times back to back
# G                         random idle gap before the next line
# C <areg hex> <value hex>  expected register value, read once idle
U 62000005 1
U 64000003 1
U 06240000 1
U 28420000 1
U 4A860000 1
G
U 6CA0000C 1
U 6E00FFFF 1
U 10EE0000 1
C 1 0005
C 2 0003
C 3 0008
C 4 FFFE
C 5 FFF6
C 6 0002
C 7 FFFF
C 8 FFFE
# mul, then independent alu ops, then dependents
U 72000123 1
U 74000456 1
U 97340000 1
U 78200010 1
U 5A460000 1
U 1D780000 1
U 3FD20000 1
C B EDC2
C C 0015
C D 000B
C E EDD7
C F ECB4
# writes to r0 are dropped
U 60200077 1
G
U 81340000 1
U 02020000 1
C 0 0000
C 1 0005
# 43 writes through the free list
U 64400001 20
U 6660FFFF 15
G
U 48840000 8
C 2 0017
C 3 FFF9
C 4 FFFE
# rd equal to rs1 behind a mul
U 8A460000 1
U 0AAA0000 1
U 8CCC0000 1
G
U 6CC00010 1
U 2EEC0000 1
C 5 FEBE
C 6 0014
C 7 FFEB

// File: dv/tb_int_backend.sv
`timescale 1ns/10ps
`default_nettype none

module tb_int_backend
    import core_types_pkg::*;
    import uop_pkg::*;
();
    localparam int    WAIT_LIMIT = 200;
    localparam string TEST_FILE  = "dv/int_backend_tests.txt";

    logic  clk;
    logic  rst;
    logic  i_uop_vld;
    uop_t  i_uop;
    logic  o_ready;
    areg_t i_dbg_areg;
    word_t o_dbg_data;
    logic  o_idle;

    integer seed;

    // last micro-op sent was a multiply that may still be stepping
    logic   mul_pending;

    int_backend_top DUT (
        .clk        (clk),
        .rst        (rst),
        .i_uop_vld  (i_uop_vld),
        .i_uop      (i_uop),
        .o_ready    (o_ready),
        .i_dbg_areg (i_dbg_areg),
        .o_dbg_data (o_dbg_data),
        .o_idle     (o_idle)
    );

    always #50 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    // o_ready only moves on rising edges, so falling-edge samples are stable
    task automatic wait_ready();
        int cycles;
        cycles = 0;
        while (o_ready !== 1'b1) begin
            if (cycles == WAIT_LIMIT) begin
                abort_run($sformatf("o_ready stayed low for %0d cycles", WAIT_LIMIT));
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (o_idle !== 1'b1) begin
            if (cycles == WAIT_LIMIT) begin
                abort_run($sformatf("o_idle stayed low for %0d cycles", WAIT_LIMIT));
            end
            cycles++;
            @(negedge clk);
        end
        mul_pending = 1'b0;
    endtask

    task automatic send_uop(input uop_t uop);
        wait_ready();
        // the multiply needs XLEN steps, so the next op is taken before idle
        if (mul_pending) begin
            check_level("o_idle", o_idle, 1'b0);
        end
        i_uop_vld = 1'b1;
        i_uop     = uop;
        @(negedge clk);
        i_uop_vld = 1'b0;
        // taken on that edge, so issue control has left IDLE
        check_level("o_ready", o_ready, 1'b0);
        mul_pending = (uop.r_fmt.op == OP_MUL);
    endtask

    // debug data is registered, one cycle behind the index
    task automatic read_dbg(input areg_t areg, output word_t value);
        i_dbg_areg = areg;
        @(negedge clk);
        value = o_dbg_data;
    endtask

    task automatic check_reg(input areg_t areg, input word_t exp);
        word_t value;
        wait_idle();
        read_dbg(areg, value);
        check_word($sformatf("o_dbg_data[r%0d]", areg), value, exp);
    endtask

    task automatic random_gap();
        int gap;
        gap = {$random(seed)} % 8;
        repeat (gap) @(negedge clk);
    endtask

    initial begin
        int               fd;
        int               rc;
        int               n_uops;
        int               n_checks;
        int unsigned      count;
        logic [7:0]       tag;
        logic [31:0]      word;
        logic [31:0]      areg_val;
        logic [31:0]      exp_val;
        logic [8*128-1:0] skip;
        logic             done;

        clk         = 1'b0;
        rst         = 1'b1;
        i_uop_vld   = 1'b0;
        i_uop       = '0;
        i_dbg_areg  = '0;
        seed        = 32'h948a59bd;
        mul_pending = 1'b0;
        n_uops      = 0;
        n_checks    = 0;

        repeat (10) @(negedge clk);
        rst = 1'b0;

        // identity map over a zeroed buffer
        check_level("o_ready", o_ready, 1'b1);
        check_level("o_idle", o_idle, 1'b1);
        for (int a = 0; a < 16; a++) begin
            check_reg(areg_t'(a), '0);
        end

        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            abort_run("could not open the test data file");
        end

        done = 1'b0;
        while (!done) begin
            rc = $fscanf(fd, " %c", tag);
            if (rc != 1) begin
                done = 1'b1;
            end else begin
                case (tag)
                    "#": rc = $fgets(skip, fd);
                    "U": begin
                        rc = $fscanf(fd, "%h %d", word, count);
                        if (rc != 2) begin
                            abort_run("malformed U line in the test data file");
                        end
                        repeat (count) send_uop(uop_t'(word));
                        n_uops += count;
                    end
                    "G": random_gap();
                    "C": begin
                        rc = $fscanf(fd, "%h %h", areg_val, exp_val);
                        if (rc != 2) begin
                            abort_run("malformed C line in the test data file");
                        end
                        check_reg(areg_t'(areg_val), word_t'(exp_val));
                        n_checks++;
                    end
                    default: begin
                        abort_run($sformatf("unknown line kind '%c' in the test data file", tag));
                    end
                endcase
            end
        end
        $fclose(fd);

        wait_idle();
        $display("%0d micro-ops sent, %0d register checks", n_uops, n_checks);
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: include/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// datapath word width
`define XLEN 16

// architectural and physical register counts
`define AREG_NUM 16
`define PREG_NUM 32

// lanes per cycle
`define RENAME_WIDTH 1
`define NUMSRCS_INT 2
`define DISPWIDTH 1

// register file ports: two operands plus debug
`define READPORT_NUM 3
// write ports: alu on 0, multiplier on 1
`define WBPORT_NUM 2

// msb:lsb range of an n-bit vector
`define WDEF(n) ((n)-1):0

`endif

// File: sim.f
+incdir+include
verilog/core_types_pkg.sv
verilog/uop_pkg.sv
verilog/exec_req_if.sv
verilog/rename_table.sv
verilog/regfile.sv
verilog/issue_ctrl.sv
verilog/exec_timer.sv
verilog/exec_units.sv
verilog/int_backend_top.sv
dv/tb_int_backend.sv

// File: verilog/core_types_pkg.sv
`default_nettype none
`include "core_macros.svh"

package core_types_pkg;

    // architectural register index
    typedef logic [`WDEF($clog2(`AREG_NUM))] areg_t;

    // physical register index, entry 0 always reads as zero
    typedef logic [`WDEF($clog2(`PREG_NUM))] iprIdx_t;

    // one data word
    typedef logic [`WDEF(`XLEN)] word_t;

endpackage

`default_nettype wire

// File: verilog/exec_req_if.sv
`timescale 1ns/10ps
`default_nettype none

interface exec_req_if
    import core_types_pkg::*;
    import uop_pkg::*;
();
    logic    launch;
    op_e     op;
    word_t   opa;
    word_t   opb;
    iprIdx_t dst;

    // launch taken by the multiplier and its step timer
    logic    mul_go;

    assign mul_go = launch && (op == OP_MUL);

    modport issuer (output launch, op, opa, opb, dst, input mul_go);
    modport unit (input launch, op, opa, opb, dst, mul_go);
endinterface

`default_nettype wire

// File: verilog/exec_timer.sv
`timescale 1ns/10ps
`default_nettype none
`include "core_macros.svh"

module exec_timer
    import core_types_pkg::*;
(
    input  wire      clk,
    input  wire      rst,
    exec_req_if.unit req,
    output logic     o_busy,
    output logic     o_step,
    output logic     o_wb_en,
    output iprIdx_t  o_wb_idx
);
    localparam int CNT_W = $clog2(`XLEN + 1);

    logic [`WDEF(CNT_W)] remain;

    always_ff @(posedge clk) begin
        if (rst) begin
            remain  <= '0;
            o_wb_en <= 1'b0;
        end else begin
            // last step done, write back next cycle unless tag is zero
            o_wb_en <= (remain == CNT_W'(1)) && (o_wb_idx != '0);
            if (req.mul_go) begin
                remain <= CNT_W'(`XLEN);
            end else if (o_step) begin
                remain <= remain - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req.mul_go) begin
            o_wb_idx <= req.dst;
        end
    end

    assign o_step = (remain != '0);
    assign o_busy = o_step || o_wb_en;

endmodule

`default_nettype wire

// File: verilog/exec_units.sv
`timescale 1ns/10ps
`default_nettype none

module exec_units
    import core_types_pkg::*;
    import uop_pkg::*;
(
    input  wire      clk,
    input  wire      rst,
    exec_req_if.unit req,
    input  wire      i_step,
    output logic     o_alu_wb_en,
    output iprIdx_t  o_alu_wb_idx,
    output word_t    o_alu_data,
    output word_t    o_mul_data
);
    logic  alu_go;
    word_t alu_res;
    word_t mcand;
    word_t mplier;

    assign alu_go = req.launch && !req.mul_go;

    always_comb begin
        case (req.op)
            OP_ADD, OP_ADDI: alu_res = req.opa + req.opb;
            OP_SUB:          alu_res = req.opa - req.opb;
            OP_XOR:          alu_res = req.opa ^ req.opb;
            default:         alu_res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_alu_wb_en <= 1'b0;
        end else begin
            o_alu_wb_en <= alu_go && (req.dst != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (alu_go) begin
            o_alu_wb_idx <= req.dst;
            o_alu_data   <= alu_res;
        end
    end

    // shift-add, one multiplier bit per step, low word kept
    always_ff @(posedge clk) begin
        if (req.mul_go) begin
            mcand      <= req.opa;
            mplier     <= req.opb;
            o_mul_data <= '0;
        end else if (i_step) begin
            if (mplier[0]) begin
                o_mul_data <= o_mul_data + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

endmodule

`default_nettype wire

// File: verilog/int_backend_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "core_macros.svh"

module int_backend_top
    import core_types_pkg::*;
    import uop_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire        i_uop_vld,
    input  wire uop_t  i_uop,
    output logic       o_ready,
    input  wire areg_t i_dbg_areg,
    output word_t      o_dbg_data,
    output logic       o_idle
);
    exec_req_if exec_req ();

    areg_t   lk_rs1;
    areg_t   lk_rs2;
    areg_t   lk_rd;
    iprIdx_t rs1_p;
    iprIdx_t rs2_p;
    iprIdx_t old_p;
    iprIdx_t new_p;
    iprIdx_t dbg_p;
    logic    alloc;
    logic    fl_empty;

    iprIdx_t                        chk_idx [`NUMSRCS_INT + 1];
    logic [`WDEF(`NUMSRCS_INT + 1)] chk_vld;
    iprIdx_t                        iss_rd_idx [`NUMSRCS_INT];
    word_t                          iss_rd_data [`NUMSRCS_INT];
    iprIdx_t                        rd_idx [`READPORT_NUM];
    word_t                          rd_data [`READPORT_NUM];
    logic [`WDEF(`READPORT_NUM)]    rd_rdy;
    logic [`WDEF(`RENAME_WIDTH)]    nr_mark;
    iprIdx_t                        nr_idx [`RENAME_WIDTH];
    logic [`WDEF(`WBPORT_NUM)]      wr_en;
    iprIdx_t                        wr_idx [`WBPORT_NUM];
    word_t                          wr_data [`WBPORT_NUM];

    logic    mul_busy;
    logic    mul_step;
    logic    mul_wb_en;
    iprIdx_t mul_wb_idx;
    logic    alu_wb_en;
    iprIdx_t alu_wb_idx;
    word_t   alu_data;
    word_t   mul_data;

    // operand ports first, debug read on the last port
    for (genvar s = 0; s < `NUMSRCS_INT; s++) begin : g_src_port
        assign rd_idx[s]      = iss_rd_idx[s];
        assign iss_rd_data[s] = rd_data[s];
    end
    assign rd_idx[`NUMSRCS_INT] = dbg_p;
    assign o_dbg_data           = rd_data[`NUMSRCS_INT];

    // the allocate strobe doubles as the not-ready mark
    assign nr_mark   = alloc;
    assign nr_idx[0] = new_p;

    assign wr_en      = {mul_wb_en, alu_wb_en};
    assign wr_idx[0]  = alu_wb_idx;
    assign wr_data[0] = alu_data;
    assign wr_idx[1]  = mul_wb_idx;
    assign wr_data[1] = mul_data;

    assign o_idle = o_ready && !mul_busy && !alu_wb_en;

    rename_table u_rename (
        .clk        (clk),
        .rst        (rst),
        .i_rs1      (lk_rs1),
        .i_rs2      (lk_rs2),
        .i_rd       (lk_rd),
        .i_alloc    (alloc),
        .i_dbg_areg (i_dbg_areg),
        .o_rs1_p    (rs1_p),
        .o_rs2_p    (rs2_p),
        .o_old_p    (old_p),
        .o_new_p    (new_p),
        .o_dbg_p    (dbg_p),
        .o_empty    (fl_empty)
    );

    regfile u_regfile (
        .clk                   (clk),
        .rst                   (rst),
        .i_notready_mark       (nr_mark),
        .i_notready_iprIdx     (nr_idx),
        .i_disp_check_iprsIdx  (chk_idx),
        .o_disp_check_iprs_vld (chk_vld),
        .i_read_idx            (rd_idx),
        .o_read_data           (rd_data),
        .o_data_rdy            (rd_rdy),
        .i_write_en            (wr_en),
        .i_write_idx           (wr_idx),
        .i_write_data          (wr_data)
    );

    issue_ctrl u_issue (
        .clk         (clk),
        .rst         (rst),
        .i_uop_vld   (i_uop_vld),
        .i_uop       (i_uop),
        .o_ready     (o_ready),
        .o_rs1       (lk_rs1),
        .o_rs2       (lk_rs2),
        .o_rd        (lk_rd),
        .o_alloc     (alloc),
        .i_rs1_p     (rs1_p),
        .i_rs2_p     (rs2_p),
        .i_old_p     (old_p),
        .i_new_p     (new_p),
        .i_empty     (fl_empty),
        .o_check_idx (chk_idx),
        .i_check_vld (chk_vld),
        .o_read_idx  (iss_rd_idx),
        .i_read_data (iss_rd_data),
        .i_read_rdy  (rd_rdy[`WDEF(`NUMSRCS_INT)]),
        .i_mul_busy  (mul_busy),
        .req         (exec_req.issuer)
    );

    exec_timer u_timer (
        .clk      (clk),
        .rst      (rst),
        .req      (exec_req.unit),
        .o_busy   (mul_busy),
        .o_step   (mul_step),
        .o_wb_en  (mul_wb_en),
        .o_wb_idx (mul_wb_idx)
    );

    exec_units u_exec (
        .clk          (clk),
        .rst          (rst),
        .req          (exec_req.unit),
        .i_step       (mul_step),
        .o_alu_wb_en  (alu_wb_en),
        .o_alu_wb_idx (alu_wb_idx),
        .o_alu_data   (alu_data),
        .o_mul_data   (mul_data)
    );

endmodule

`default_nettype wire

// File: verilog/issue_ctrl.sv
`timescale 1ns/10ps
`default_nettype none
`include "core_macros.svh"

module issue_ctrl
    import core_types_pkg::*;
    import uop_pkg::*;
(
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            i_uop_vld,
    input  wire uop_t                      i_uop,
    output logic                           o_ready,
    // rename lookup and allocation
    output areg_t                          o_rs1,
    output areg_t                          o_rs2,
    output areg_t                          o_rd,
    output logic                           o_alloc,
    input  wire iprIdx_t                   i_rs1_p,
    input  wire iprIdx_t                   i_rs2_p,
    input  wire iprIdx_t                   i_old_p,
    input  wire iprIdx_t                   i_new_p,
    input  wire                            i_empty,
    // dispatch check
    output iprIdx_t                        o_check_idx [`NUMSRCS_INT + 1],
    input  wire [`WDEF(`NUMSRCS_INT + 1)]  i_check_vld,
    // operand reads
    output iprIdx_t                        o_read_idx [`NUMSRCS_INT],
    input  wire word_t                     i_read_data [`NUMSRCS_INT],
    input  wire [`WDEF(`NUMSRCS_INT)]      i_read_rdy,
    input  wire                            i_mul_busy,
    exec_req_if.issuer                     req
);
    typedef enum logic [1:0] {
        IDLE,
        CHECK,
        READ
    } state_e;

    state_e  state;
    uop_t    uop_q;
    iprIdx_t dst_q;
    op_e     op;
    logic    has_imm;
    logic    srcs_rdy;
    logic    go;

    assign op      = uop_q.r_fmt.op;
    assign has_imm = uop_has_imm(op);
    assign o_ready = (state == IDLE);

    assign o_rs1 = uop_q.r_fmt.rs1;
    assign o_rs2 = uop_q.r_fmt.rs2;
    assign o_rd  = uop_q.r_fmt.rd;

    assign o_check_idx[0] = i_rs1_p;
    assign o_check_idx[1] = i_rs2_p;
    assign o_check_idx[2] = i_old_p;

    // immediate forms have no second source to wait on
    assign srcs_rdy = i_check_vld[0] && (has_imm || i_check_vld[1]) && i_check_vld[2];
    assign go       = (state == CHECK) && srcs_rdy && !i_empty
                   && !((op == OP_MUL) && i_mul_busy);
    assign o_alloc  = go && (uop_q.r_fmt.rd != '0);

    // read data lands in READ, taken from the last CHECK cycle
    assign o_read_idx[0] = i_rs1_p;
    assign o_read_idx[1] = i_rs2_p;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (i_uop_vld) begin
                        state <= CHECK;
                    end
                end
                CHECK: begin
                    if (go) begin
                        state <= READ;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (o_ready && i_uop_vld) begin
            uop_q <= i_uop;
        end
        // rd 0 lands on the hard zero register
        if (go) begin
            dst_q <= o_alloc ? i_new_p : '0;
        end
    end

    assign req.launch = (state == READ);
    assign req.op     = op;
    assign req.opa    = i_read_data[0];
    assign req.opb    = has_imm ? uop_q.i_fmt.imm : i_read_data[1];
    assign req.dst    = dst_q;

    a_mul_timer_free: assert property (@(posedge clk) disable iff (rst)
        req.mul_go |-> !i_mul_busy);

    a_operands_ready: assert property (@(posedge clk) disable iff (rst)
        req.launch |-> i_read_rdy[0] && (has_imm || i_read_rdy[1]));

endmodule

`default_nettype wire

// File: verilog/regfile.sv
`timescale 1ns/10ps
`default_nettype none
`include "core_macros.svh"

module regfile
    import core_types_pkg::*;
#(
    parameter int READPORT_NUM = `READPORT_NUM,
    parameter int WBPORT_NUM   = `WBPORT_NUM,
    parameter int DISPWIDTH    = `DISPWIDTH,
    parameter int SIZE         = `PREG_NUM
)(
    input  wire                                    clk,
    input  wire                                    rst,
    // newly renamed destinations go not ready
    input  wire [`WDEF(`RENAME_WIDTH)]             i_notready_mark,
    input  wire iprIdx_t                           i_notready_iprIdx [`RENAME_WIDTH],
    // sources plus old destination per dispatched op
    input  wire iprIdx_t      i_disp_check_iprsIdx [DISPWIDTH * (`NUMSRCS_INT + 1)],
    output logic [`WDEF(DISPWIDTH * (`NUMSRCS_INT + 1))] o_disp_check_iprs_vld,
    input  wire iprIdx_t                           i_read_idx [READPORT_NUM],
    output word_t                                  o_read_data [READPORT_NUM],
    output logic [`WDEF(READPORT_NUM)]             o_data_rdy,
    input  wire [`WDEF(WBPORT_NUM)]                i_write_en,
    input  wire iprIdx_t                           i_write_idx [WBPORT_NUM],
    input  wire word_t                             i_write_data [WBPORT_NUM]
);
    localparam int CHECK_NUM = DISPWIDTH * (`NUMSRCS_INT + 1);

    word_t              buffer [SIZE];
    logic [`WDEF(SIZE)] rdy_bit;
    logic [`WDEF(SIZE)] rdy_bypass;
    word_t              rd_value [READPORT_NUM];

    // a writeback wins over a not-ready mark in the same cycle
    always_comb begin
        rdy_bypass = rdy_bit;
        for (int m = 0; m < `RENAME_WIDTH; m++) begin
            if (i_notready_mark[m]) begin
                rdy_bypass[i_notready_iprIdx[m]] = 1'b0;
            end
        end
        for (int w = 0; w < WBPORT_NUM; w++) begin
            if (i_write_en[w]) begin
                rdy_bypass[i_write_idx[w]] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rdy_bit <= '1;
            for (int k = 0; k < SIZE; k++) begin
                buffer[k] <= '0;
            end
        end else begin
            rdy_bit <= rdy_bypass;
            for (int w = 0; w < WBPORT_NUM; w++) begin
                if (i_write_en[w]) begin
                    buffer[i_write_idx[w]] <= i_write_data[w];
                end
            end
        end
    end

    // forward same-cycle writes so a bypassed dispatch reads fresh data
    always_comb begin
        for (int r = 0; r < READPORT_NUM; r++) begin
            rd_value[r] = buffer[i_read_idx[r]];
            for (int w = 0; w < WBPORT_NUM; w++) begin
                if (i_write_en[w] && (i_write_idx[w] == i_read_idx[r])) begin
                    rd_value[r] = i_write_data[w];
                end
            end
            if (i_read_idx[r] == '0) begin
                rd_value[r] = '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int r = 0; r < READPORT_NUM; r++) begin
            o_read_data[r] <= rd_value[r];
            o_data_rdy[r]  <= (i_read_idx[r] == '0) || rdy_bypass[i_read_idx[r]];
        end
    end

    always_comb begin
        for (int c = 0; c < CHECK_NUM; c++) begin
            o_disp_check_iprs_vld[c] = (i_disp_check_iprsIdx[c] == '0)
                                     || rdy_bypass[i_disp_check_iprsIdx[c]];
        end
    end

    // every producer was marked at rename, long before its result
    for (genvar w = 0; w < WBPORT_NUM; w++) begin : g_wr_chk
        a_write_not_ready: assert property (@(posedge clk) disable iff (rst)
            i_write_en[w] |-> !rdy_bit[i_write_idx[w]]);
    end

endmodule

`default_nettype wire

// File: verilog/rename_table.sv
`timescale 1ns/10ps
`default_nettype none
`include "core_macros.svh"

module rename_table
    import core_types_pkg::*;
(
    input  wire          clk,
    input  wire          rst,
    input  wire areg_t   i_rs1,
    input  wire areg_t   i_rs2,
    input  wire areg_t   i_rd,
    input  wire          i_alloc,
    input  wire areg_t   i_dbg_areg,
    output iprIdx_t      o_rs1_p,
    output iprIdx_t      o_rs2_p,
    output iprIdx_t      o_old_p,
    output iprIdx_t      o_new_p,
    output iprIdx_t      o_dbg_p,
    output logic         o_empty
);
    localparam int PTR_W = $clog2(`PREG_NUM);
    localparam int CNT_W = $clog2(`PREG_NUM + 1);

    iprIdx_t             map [`AREG_NUM];
    iprIdx_t             free_list [`PREG_NUM];
    logic [`WDEF(PTR_W)] head;
    logic [`WDEF(PTR_W)] tail;
    logic [`WDEF(CNT_W)] count;
    logic                push;

    // lookups are combinational
    assign o_rs1_p = map[i_rs1];
    assign o_rs2_p = map[i_rs2];
    assign o_old_p = map[i_rd];
    assign o_dbg_p = map[i_dbg_areg];
    assign o_new_p = free_list[head];
    assign o_empty = (count == '0);

    // the replaced tag goes back on the list, zero never does
    assign push = i_alloc && (o_old_p != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= PTR_W'(`PREG_NUM - `AREG_NUM);
            count <= CNT_W'(`PREG_NUM - `AREG_NUM);
            // identity map, upper half free
            for (int a = 0; a < `AREG_NUM; a++) begin
                map[a] <= iprIdx_t'(a);
            end
            for (int f = 0; f < `PREG_NUM; f++) begin
                free_list[f] <= iprIdx_t'(f + `AREG_NUM);
            end
        end else if (i_alloc) begin
            map[i_rd] <= free_list[head];
            head      <= head + 1'b1;
            if (push) begin
                free_list[tail] <= o_old_p;
                tail            <= tail + 1'b1;
            end
            count <= push ? count : count - 1'b1;
        end
    end

    a_no_alloc_empty: assert property (@(posedge clk) disable iff (rst)
        i_alloc |-> !o_empty);

    a_count_bound: assert property (@(posedge clk) disable iff (rst)
        count <= CNT_W'(`PREG_NUM - 1));

endmodule

`default_nettype wire

// File: verilog/uop_pkg.sv
`default_nettype none
`include "core_macros.svh"

package uop_pkg;
    import core_types_pkg::*;

    localparam int UOP_W = 32;

    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_XOR  = 3'd2,
        OP_ADDI = 3'd3,
        OP_MUL  = 3'd4
    } op_e;

    // register-register form
    typedef struct packed {
        op_e   op;
        areg_t rd;
        areg_t rs1;
        areg_t rs2;
        logic [`WDEF(UOP_W - $bits(op_e) - 3 * $bits(areg_t))] pad;
    } r_fmt_t;

    // register-immediate form, immediate in the low bits
    typedef struct packed {
        op_e   op;
        areg_t rd;
        areg_t rs1;
        logic [`WDEF(UOP_W - $bits(op_e) - 2 * $bits(areg_t) - $bits(word_t))] pad;
        word_t imm;
    } i_fmt_t;

    // op, rd and rs1 sit at the same place in both views
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } uop_t;

    function automatic logic uop_has_imm(op_e op);
        return op == OP_ADDI;
    endfunction

endpackage

`default_nettype wire
